/* logic/rv_pkg.sv */
package rv_pkg;

    localparam int mem_words = 1024;
    localparam int mem_addr_bits = $clog2(mem_words);
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_wait,
        st_execute,
        st_mem,
        st_mem_wait,
        st_halt
    } core_state_e;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_eq, alu_ne
    } alu_op_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4, wb_imm} wb_sel_e;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      reg_wen;
        wb_sel_e   wb_sel;
        logic      is_load;
        logic      is_store;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      is_branch;
        logic      branch_on_zero;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
    } dec_ctrl_t;

endpackage

/* logic/mem_bus_if.sv */
interface mem_bus_if;

    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;

    // request side holds req and payload until gnt
    modport requester (
        output req, we, addr, wdata, wmask,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata, wmask,
        output gnt, rvalid, rdata
    );

endinterface

/* logic/rv_decoder.sv */
module rv_decoder
    import rv_pkg::*;
(
    input  logic [31:0] inst,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic [31:0] imm,
    output dec_ctrl_t   ctrl
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // funct3 to ALU op, sub only for register form
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_en,
                                         input logic sra_en);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_en ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = sra_en ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // all immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl          = '0;
        ctrl.mem_size = size_word;
        imm           = imm_i;
        case (opcode)
            op_lui: begin
                imm          = imm_u;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = wb_imm;
            end
            op_auipc: begin
                imm              = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen     = 1'b1;
            end
            op_jal: begin
                imm          = imm_j;
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel  = wb_pc_plus4;
            end
            op_jalr: begin
                // target comes from the ALU add
                ctrl.is_jalr     = (funct3 == 3'b000);
                ctrl.reg_wen     = (funct3 == 3'b000);
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_sel      = wb_pc_plus4;
            end
            op_branch: begin
                imm            = imm_b;
                ctrl.is_branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_eq;
                    3'b001:  ctrl.alu_op = alu_ne;
                    3'b100:  ctrl.alu_op = alu_slt;
                    3'b101:  ctrl.alu_op = alu_slt;
                    3'b110:  ctrl.alu_op = alu_sltu;
                    3'b111:  ctrl.alu_op = alu_sltu;
                    default: ctrl.is_branch = 1'b0;
                endcase
                // bge and bgeu branch when the compare is false
                ctrl.branch_on_zero = (funct3 == 3'b101) || (funct3 == 3'b111);
            end
            op_load: begin
                ctrl.is_load       = 1'b1;
                ctrl.reg_wen       = 1'b1;
                ctrl.wb_sel        = wb_mem;
                ctrl.src2_is_imm   = 1'b1;
                ctrl.load_unsigned = funct3[2];
                case (funct3)
                    3'b000, 3'b100: ctrl.mem_size = size_byte;
                    3'b001, 3'b101: ctrl.mem_size = size_half;
                    3'b010:         ctrl.mem_size = size_word;
                    default: begin
                        ctrl.is_load = 1'b0;
                        ctrl.reg_wen = 1'b0;
                    end
                endcase
            end
            op_store: begin
                imm              = imm_s;
                ctrl.is_store    = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_size = size_byte;
                    3'b001:  ctrl.mem_size = size_half;
                    3'b010:  ctrl.mem_size = size_word;
                    default: ctrl.is_store = 1'b0;
                endcase
            end
            op_imm: begin
                ctrl.alu_op      = arith_op(funct3, 1'b0, alt);
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen     = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op  = arith_op(funct3, alt, alt);
                ctrl.reg_wen = 1'b1;
            end
            op_system: ctrl.is_ebreak = (inst == 32'h0010_0073);
            // unknown encodings fall through as no-ops
            default: ;
        endcase
    end

endmodule

/* logic/rv_alu.sv */
module rv_alu
    import rv_pkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            // compares give 0 or 1 for the branch decision
            alu_eq:   result = {31'b0, a == b};
            alu_ne:   result = {31'b0, a != b};
            default:  result = a + b;
        endcase
    end

endmodule

/* logic/rv_regfile.sv */
module rv_regfile (
    input  logic        clk,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero whatever the array holds
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

/* logic/rv_core.sv */
module rv_core
    import rv_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         run,
    mem_bus_if.requester bus,
    output logic         halted,
    output logic [31:0]  halt_pc
);

    core_state_e state;
    logic [31:0] pc;
    logic [31:0] ir;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    dec_ctrl_t   ctrl;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic        take_branch;
    logic [1:0]  byte_off;
    logic [31:0] load_shift;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic        wb_en;

    rv_decoder i_rv_decoder (
        .inst (ir),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm),
        .ctrl (ctrl)
    );

    rv_regfile i_rv_regfile (
        .clk    (clk),
        .wen    (wb_en),
        .waddr  (rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign alu_a = ctrl.src1_is_pc ? pc : rs1_data;
    assign alu_b = ctrl.src2_is_imm ? imm : rs2_data;

    rv_alu i_rv_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    assign pc_plus4    = pc + 32'd4;
    assign take_branch = ctrl.is_branch && (alu_result[0] != ctrl.branch_on_zero);

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (ctrl.is_jal || take_branch) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // fetch uses pc, data access uses rs1 + imm
    assign bus.req  = (state == st_fetch) || (state == st_mem);
    assign bus.we   = (state == st_mem) && ctrl.is_store;
    assign bus.addr = (state == st_mem) ? alu_result : pc;
    assign byte_off = alu_result[1:0];

    // store data replicated into every lane, mask picks the lane
    always_comb begin
        case (ctrl.mem_size)
            size_byte: begin
                bus.wdata = {4{rs2_data[7:0]}};
                bus.wmask = 4'b0001 << byte_off;
            end
            size_half: begin
                bus.wdata = {2{rs2_data[15:0]}};
                bus.wmask = 4'b0011 << {byte_off[1], 1'b0};
            end
            default: begin
                bus.wdata = rs2_data;
                bus.wmask = 4'b1111;
            end
        endcase
    end

    assign load_shift = bus.rdata >> {byte_off, 3'b000};

    always_comb begin
        case (ctrl.mem_size)
            size_byte: load_data = ctrl.load_unsigned ? {24'b0, load_shift[7:0]}
                                                      : {{24{load_shift[7]}}, load_shift[7:0]};
            size_half: load_data = ctrl.load_unsigned ? {16'b0, load_shift[15:0]}
                                                      : {{16{load_shift[15]}}, load_shift[15:0]};
            default:   load_data = bus.rdata;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:      wb_data = load_data;
            wb_pc_plus4: wb_data = pc_plus4;
            wb_imm:      wb_data = imm;
            default:     wb_data = alu_result;
        endcase
    end

    // loads write back once the read data arrives
    assign wb_en = ((state == st_execute) && ctrl.reg_wen && !ctrl.is_load)
                 || ((state == st_mem_wait) && ctrl.is_load && bus.rvalid);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            pc      <= reset_pc;
            halt_pc <= 32'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (run) state <= st_fetch;
                end
                st_fetch: begin
                    if (bus.gnt) state <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (bus.rvalid) state <= st_execute;
                end
                st_execute: begin
                    if (ctrl.is_ebreak) begin
                        halt_pc <= pc;
                        state   <= st_halt;
                    end else if (ctrl.is_load || ctrl.is_store) begin
                        state <= st_mem;
                    end else begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                st_mem: begin
                    if (bus.gnt) state <= st_mem_wait;
                end
                st_mem_wait: begin
                    // a store has no rvalid and leaves after one cycle
                    if (ctrl.is_store || bus.rvalid) begin
                        pc    <= pc_plus4;
                        state <= st_fetch;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_fetch_wait) && bus.rvalid) begin
            ir <= bus.rdata;
        end
    end

    assign halted = (state == st_halt);

endmodule

/* logic/mem_arbiter.sv */
module mem_arbiter
    import rv_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    mem_bus_if.arbiter               host,
    mem_bus_if.arbiter               core,
    input  logic [31:0]              ram_rdata,
    output logic                     ram_en,
    output logic                     ram_we,
    output logic [mem_addr_bits-1:0] ram_addr,
    output logic [31:0]              ram_wdata,
    output logic [3:0]               ram_wmask
);

    logic host_read_pend;
    logic core_read_pend;

    // host has fixed priority
    assign host.gnt = host.req;
    assign core.gnt = core.req && !host.req;

    assign ram_en    = host.req || core.req;
    assign ram_we    = host.req ? host.we : core.we;
    assign ram_addr  = host.req ? host.addr[mem_addr_bits+1:2] : core.addr[mem_addr_bits+1:2];
    assign ram_wdata = host.req ? host.wdata : core.wdata;
    assign ram_wmask = host.req ? host.wmask : core.wmask;

    // owner of the read that returns next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            host_read_pend <= 1'b0;
            core_read_pend <= 1'b0;
        end else begin
            host_read_pend <= host.gnt && !host.we;
            core_read_pend <= core.gnt && !core.we;
        end
    end

    assign host.rvalid = host_read_pend;
    assign core.rvalid = core_read_pend;
    assign host.rdata  = ram_rdata;
    assign core.rdata  = ram_rdata;

endmodule

/* logic/data_ram.sv */
module data_ram
    import rv_pkg::*;
(
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [mem_addr_bits-1:0] addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wmask,
    output logic [31:0]              rdata
);

    logic [31:0] mem [mem_words];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int i = 0; i < 4; i++) begin
                    if (wmask[i]) mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* logic/rv_subsystem.sv */
module rv_subsystem
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        host_req,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    input  logic [3:0]  host_wmask,
    output logic        host_gnt,
    output logic        host_rvalid,
    output logic [31:0] host_rdata,
    output logic        halted,
    output logic [31:0] halt_pc
);

    logic                     ram_en;
    logic                     ram_we;
    logic [mem_addr_bits-1:0] ram_addr;
    logic [31:0]              ram_wdata;
    logic [3:0]               ram_wmask;
    logic [31:0]              ram_rdata;

    mem_bus_if host_bus ();
    mem_bus_if core_bus ();

    // host pins onto its bus
    assign host_bus.req   = host_req;
    assign host_bus.we    = host_we;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_bus.wmask = host_wmask;
    assign host_gnt       = host_bus.gnt;
    assign host_rvalid    = host_bus.rvalid;
    assign host_rdata     = host_bus.rdata;

    mem_arbiter i_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .host      (host_bus),
        .core      (core_bus),
        .ram_rdata (ram_rdata),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask)
    );

    data_ram i_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .rdata (ram_rdata)
    );

    rv_core i_rv_core (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .bus     (core_bus),
        .halted  (halted),
        .halt_pc (halt_pc)
    );

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* sim/tb_rv_subsystem.sv */
module tb_rv_subsystem
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] cont_addr = (mem_words - 1) * 4;

    logic        clk;
    logic        reset;
    logic        run;
    logic        host_req;
    logic        host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic [3:0]  host_wmask;
    logic        host_gnt;
    logic        host_rvalid;
    logic [31:0] host_rdata;
    logic        halted;
    logic [31:0] halt_pc;

    logic [31:0] rng_state = 32'd79874;
    logic [31:0] prog[$];
    logic [31:0] exp_mem[int];
    logic [31:0] exp_rdata;
    logic [31:0] exp_halt_pc;
    logic        chk_read;
    logic        started;
    logic        prog_ready;
    int          res_ptr;
    int          wd_limit;

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    rv_subsystem i_rv_subsystem (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_wmask  (host_wmask),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .halted      (halted),
        .halt_pc     (halt_pc)
    );

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] expv);
        $display("[ERROR] %s: got %h, expected %h", name, got, expv);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic int cur_pc();
        return prog.size() * 4;
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    // lui plus addi, upper part rounded for the signed low half
    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = val + 32'h800;
        emit(enc_u(upper[31:12], rd, op_lui));
        emit(enc_i(val[11:0], rd, 3'b000, rd, op_imm));
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] expv);
        emit(enc_s(res_ptr[11:0], rs, 5'd0, 3'b010));
        exp_mem[res_ptr] = expv;
        res_ptr += 4;
    endtask

    task automatic build_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] ims;
        logic [4:0]  sh;
        int          p;
        a   = next_rand();
        b   = next_rand();
        im  = next_rand();
        ims = {{20{im[11]}}, im[11:0]};
        sh  = im[4:0];
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        store_result(5'd3, a + b);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
        store_result(5'd3, a - b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3));
        store_result(5'd3, a << b[4:0]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3));
        store_result(5'd3, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd3));
        store_result(5'd3, (a < b) ? 32'd1 : 32'd0);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3));
        store_result(5'd3, a ^ b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd3));
        store_result(5'd3, a >> b[4:0]);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
        store_result(5'd3, $signed(a) >>> b[4:0]);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3));
        store_result(5'd3, a | b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3));
        store_result(5'd3, a & b);
        // immediate forms
        emit(enc_i(im[11:0], 5'd1, 3'd0, 5'd3, op_imm));
        store_result(5'd3, a + ims);
        emit(enc_i(im[11:0], 5'd1, 3'd2, 5'd3, op_imm));
        store_result(5'd3, ($signed(a) < $signed(ims)) ? 32'd1 : 32'd0);
        emit(enc_i(im[11:0], 5'd1, 3'd3, 5'd3, op_imm));
        store_result(5'd3, (a < ims) ? 32'd1 : 32'd0);
        emit(enc_i(im[11:0], 5'd1, 3'd4, 5'd3, op_imm));
        store_result(5'd3, a ^ ims);
        emit(enc_i(im[11:0], 5'd1, 3'd6, 5'd3, op_imm));
        store_result(5'd3, a | ims);
        emit(enc_i(im[11:0], 5'd1, 3'd7, 5'd3, op_imm));
        store_result(5'd3, a & ims);
        emit(enc_i({7'h00, sh}, 5'd1, 3'd1, 5'd3, op_imm));
        store_result(5'd3, a << sh);
        emit(enc_i({7'h00, sh}, 5'd1, 3'd5, 5'd3, op_imm));
        store_result(5'd3, a >> sh);
        emit(enc_i({7'h20, sh}, 5'd1, 3'd5, 5'd3, op_imm));
        store_result(5'd3, $signed(a) >>> sh);
        p = cur_pc();
        emit(enc_u(im[31:12], 5'd3, op_auipc));
        store_result(5'd3, p + {im[31:12], 12'h000});
    endtask

    // sb and sh into the word at 0x600, then every load width back
    task automatic build_mem(input logic [31:0] w_init);
        logic [31:0] v;
        logic [31:0] w;
        v = next_rand() | 32'h0000_8080;
        w = w_init;
        load_const(5'd5, v);
        emit(enc_s(12'h601, 5'd5, 5'd0, 3'b000));
        emit(enc_s(12'h602, 5'd5, 5'd0, 3'b001));
        w[15:8]  = v[7:0];
        w[31:16] = v[15:0];
        emit(enc_i(12'h601, 5'd0, 3'b000, 5'd6, op_load));
        store_result(5'd6, {{24{w[15]}}, w[15:8]});
        emit(enc_i(12'h601, 5'd0, 3'b100, 5'd6, op_load));
        store_result(5'd6, {24'h0, w[15:8]});
        emit(enc_i(12'h602, 5'd0, 3'b001, 5'd6, op_load));
        store_result(5'd6, {{16{w[31]}}, w[31:16]});
        emit(enc_i(12'h602, 5'd0, 3'b101, 5'd6, op_load));
        store_result(5'd6, {16'h0, w[31:16]});
        emit(enc_i(12'h600, 5'd0, 3'b010, 5'd6, op_load));
        store_result(5'd6, w);
        exp_mem[32'h600] = w;
    endtask

    task automatic build_ctrl();
        int n;
        int q;
        n = 3 + (next_rand() % 5);
        emit(enc_i(12'(n), 5'd0, 3'd0, 5'd7, op_imm));
        // beq exits forward, jal loops back
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd6, op_imm));
        emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, op_imm));
        emit(enc_b(13'd8, 5'd7, 5'd6, 3'b000));
        emit(enc_j(21'(-8), 5'd0));
        store_result(5'd6, n);
        // bne, blt, bltu loop while counter is below n
        for (int k = 0; k < 3; k++) begin
            emit(enc_i(12'd0, 5'd0, 3'd0, 5'd6, op_imm));
            emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, op_imm));
            emit(enc_b(13'(-4), 5'd7, 5'd6, (k == 0) ? 3'b001 : (k == 1) ? 3'b100 : 3'b110));
            store_result(5'd6, n);
        end
        // bge, bgeu loop while n >= counter
        for (int k = 0; k < 2; k++) begin
            emit(enc_i(12'd0, 5'd0, 3'd0, 5'd6, op_imm));
            emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, op_imm));
            emit(enc_b(13'(-4), 5'd6, 5'd7, (k == 0) ? 3'b101 : 3'b111));
            store_result(5'd6, n + 1);
        end
        // jal and jalr each skip one instruction
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd9, op_imm));
        q = cur_pc();
        emit(enc_j(21'd8, 5'd8));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, op_imm));
        store_result(5'd8, q + 4);
        q = cur_pc();
        emit(enc_i(12'(q + 13), 5'd0, 3'd0, 5'd10, op_imm));
        emit(enc_i(12'd0, 5'd10, 3'd0, 5'd11, op_jalr));
        emit(enc_i(12'd1, 5'd9, 3'd0, 5'd9, op_imm));
        store_result(5'd11, q + 8);
        store_result(5'd9, 32'd0);
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        host_wmask = 4'hf;
        do @(posedge clk); while (!host_gnt);
        @(negedge clk);
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    // starts and ends on a falling edge
    task automatic host_read(input logic [31:0] addr, input logic [31:0] expv);
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        exp_rdata = expv;
        do @(posedge clk); while (!host_gnt);
        @(negedge clk);
        host_req = 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    a_read_data: assert property (@(posedge clk) disable iff (reset)
        (chk_read && host_rvalid) |-> (host_rdata == exp_rdata))
        else fail_value("host_rdata", $sampled(host_rdata), $sampled(exp_rdata));

    a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (reset)
        (host_gnt && !host_we) |=> host_rvalid)
        else fail_plain("host read got no rvalid one cycle after its grant");

    a_rvalid_cause: assert property (@(posedge clk) disable iff (reset)
        host_rvalid |-> $past(host_gnt && !host_we))
        else fail_plain("host rvalid without a read granted the cycle before");

    a_halt_pc: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) |-> (halt_pc == exp_halt_pc))
        else fail_value("halt_pc", $sampled(halt_pc), $sampled(exp_halt_pc));

    a_halt_hold: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else fail_plain("halted dropped while reset was low");

    a_no_early_halt: assert property (@(posedge clk) disable iff (reset)
        !started |-> !halted)
        else fail_plain("core halted before run was raised");

    initial begin
        wait (prog_ready);
        repeat (wd_limit) @(posedge clk);
        fail_plain("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] rt_data [16];
        logic [31:0] w_init;
        logic [31:0] cont_word;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = 32'd0;
        host_wdata = 32'd0;
        host_wmask = 4'h0;
        exp_rdata  = 32'd0;
        chk_read   = 1'b0;
        started    = 1'b0;
        prog_ready = 1'b0;
        res_ptr    = 32'h400;
        w_init     = next_rand();
        cont_word  = next_rand();
        build_alu();
        build_alu();
        build_mem(w_init);
        build_ctrl();
        exp_halt_pc = cur_pc();
        emit(32'h0010_0073);
        wd_limit   = prog.size() * 200 + (prog.size() + exp_mem.size() * 2 + 64) * 8 + 200;
        prog_ready = 1'b1;

        wait (reset === 1'b0);
        @(negedge clk);
        chk_read = 1'b1;
        // host round trip with the core idle
        for (int i = 0; i < 16; i++) begin
            rt_data[i] = next_rand();
            host_write(32'hA00 + 4 * i, rt_data[i]);
        end
        for (int i = 0; i < 16; i++) begin
            host_read(32'hA00 + 4 * i, rt_data[i]);
        end

        foreach (prog[i]) begin
            host_write(4 * i, prog[i]);
        end
        host_write(32'h600, w_init);
        host_write(cont_addr, cont_word);

        // host keeps polling one word while the core runs
        run     = 1'b1;
        started = 1'b1;
        while (!halted) begin
            host_read(cont_addr, cont_word);
        end

        foreach (exp_mem[a]) begin
            host_read(a, exp_mem[a]);
        end
        repeat (50) @(negedge clk);
        foreach (exp_mem[a]) begin
            host_read(a, exp_mem[a]);
        end
        host_read(cont_addr, cont_word);

        $display("Done: no errors");
        $finish;
    end

endmodule

/* flist.f */
logic/rv_pkg.sv
logic/mem_bus_if.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_core.sv
logic/mem_arbiter.sv
logic/data_ram.sv
logic/rv_subsystem.sv
sim/tb_clock.sv
sim/tb_rv_subsystem.sv

/* Bender.yml */
package:
  name: rv_subsystem

sources:
  - logic/rv_pkg.sv
  - logic/mem_bus_if.sv
  - logic/rv_decoder.sv
  - logic/rv_alu.sv
  - logic/rv_regfile.sv
  - logic/rv_core.sv
  - logic/mem_arbiter.sv
  - logic/data_ram.sv
  - logic/rv_subsystem.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_rv_subsystem.sv
